//--- hw/sdlc_rx_config.svh
`ifndef SDLC_RX_CONFIG_SVH
`define SDLC_RX_CONFIG_SVH

// bit timing, in clk cycles
`define SDLC_BIT_CLKS 16
`define SDLC_PHASE_W 4      // 2**SDLC_PHASE_W must equal SDLC_BIT_CLKS

// framing
`define SDLC_STUFF_ONES 5   // a 0 after this many ones is stuffing
`define SDLC_FLAG_ONES 6    // a 0 after this many ones closes a flag
`define SDLC_BYTE_W 8

// slicer integrator, signed
`define SDLC_SLICE_W 6

`endif

//--- hw/sdlc_rx_pkg.sv
`default_nettype none

`include "sdlc_rx_config.svh"

package sdlc_rx_pkg;

    // position inside one bit period
    typedef logic [`SDLC_PHASE_W-1:0] phase_t;

    // up/down line integrator
    typedef logic signed [`SDLC_SLICE_W-1:0] slice_acc_t;

    // consecutive ones seen, saturates at the flag length
    typedef logic [2:0] ones_run_t;

    typedef logic [`SDLC_BYTE_W-1:0] rx_byte_t;

endpackage

`default_nettype wire

//--- hw/clock_recovery.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdlc_rx_config.svh"

module clock_recovery (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rx_clk,
    output logic                bit_strobe,
    output sdlc_rx_pkg::phase_t phase
);
    import sdlc_rx_pkg::*;

    localparam phase_t HALF = phase_t'(`SDLC_BIT_CLKS / 2);

    logic       rx_clk_meta;
    logic       rx_clk_sync;
    logic       rx_clk_prev;
    logic       rx_rise;
    logic       late;
    logic       early;
    logic [1:0] step;
    logic       carry;
    phase_t     phase_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_clk_meta <= 1'b0;
            rx_clk_sync <= 1'b0;
            rx_clk_prev <= 1'b0;
        end else begin
            rx_clk_meta <= rx_clk;          // first sync stage
            rx_clk_sync <= rx_clk_meta;
            rx_clk_prev <= rx_clk_sync;     // for edge detect
        end
    end

    assign rx_rise = rx_clk_sync & ~rx_clk_prev;

    // edge at phase 0 means we are aligned, leave the counter alone
    assign late  = rx_rise && (phase != '0) && (phase < HALF);
    assign early = rx_rise && (phase >= HALF);

    always_comb begin
        if (late) begin
            step = 2'd0;                    // stretch period to 17
        end else if (early) begin
            step = 2'd2;                    // shorten period to 15
        end else begin
            step = 2'd1;
        end
    end

    assign {carry, phase_next} = {1'b0, phase} + {{(`SDLC_PHASE_W - 1){1'b0}}, step};

    // strobe lands in the cycle the counter shows the new period
    always_ff @(posedge clk) begin
        if (reset) begin
            phase      <= '0;
            bit_strobe <= 1'b0;
        end else begin
            phase      <= phase_next;
            bit_strobe <= carry;
        end
    end

    // a wrap leaves the counter at 0 or 1, far from the next one
    a_strobe_spaced: assert property (
        @(posedge clk) disable iff (reset)
        bit_strobe |=> !bit_strobe
    );

endmodule

`default_nettype wire

//--- hw/bit_slicer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdlc_rx_config.svh"

module bit_slicer (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      rx_data,
    input  wire                      bit_strobe,
    input  wire sdlc_rx_pkg::phase_t phase,
    output logic                     bit_valid,
    output logic                     bit_value
);
    import sdlc_rx_pkg::*;

    localparam slice_acc_t ACC_MAX = {1'b0, {(`SDLC_SLICE_W - 1){1'b1}}};
    localparam slice_acc_t ACC_MIN = {1'b1, {(`SDLC_SLICE_W - 1){1'b0}}};

    logic       rx_data_meta;
    logic       rx_data_sync;
    slice_acc_t acc;

    always_ff @(posedge clk) begin
        rx_data_meta <= rx_data;
        rx_data_sync <= rx_data_meta;   // same depth as the rx_clk path
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            bit_valid <= 1'b0;
        end else begin
            bit_valid <= bit_strobe;
            if (bit_strobe) begin
                acc <= '0;              // restart for the next bit
            end else if (phase != '0) begin
                if (rx_data_sync && (acc != ACC_MAX)) begin
                    acc <= acc + slice_acc_t'(1);
                end else if (!rx_data_sync && (acc != ACC_MIN)) begin
                    acc <= acc - slice_acc_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_strobe) begin
            bit_value <= (acc > 0);     // majority of the period
        end
    end

    a_acc_no_wrap: assert property (
        @(posedge clk) disable iff (reset)
        !bit_strobe |=> (acc == $past(acc)) || (acc == $past(acc) + 1) ||
                        (acc == $past(acc) - 1)
    );

endmodule

`default_nettype wire

//--- hw/hdlc_deframer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdlc_rx_config.svh"

module hdlc_deframer (
    input  wire  clk,
    input  wire  reset,
    input  wire  bit_valid,
    input  wire  bit_value,
    output logic data_valid,
    output logic data_bit,
    output logic flag
);
    import sdlc_rx_pkg::*;

    localparam ones_run_t STUFF_RUN = ones_run_t'(`SDLC_STUFF_ONES);
    localparam ones_run_t FLAG_RUN  = ones_run_t'(`SDLC_FLAG_ONES);

    ones_run_t ones_run;
    logic      pass_bit;
    logic      flag_hit;

    always_comb begin
        pass_bit = 1'b0;
        flag_hit = 1'b0;
        if (bit_valid) begin
            if (bit_value) begin
                pass_bit = (ones_run != FLAG_RUN);  // drop ones past six
            end else if (ones_run == FLAG_RUN) begin
                flag_hit = 1'b1;                    // 01111110 closes here
            end else begin
                pass_bit = (ones_run != STUFF_RUN); // stuffed zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ones_run   <= '0;
            data_valid <= 1'b0;
            flag       <= 1'b0;
        end else begin
            data_valid <= pass_bit;
            flag       <= flag_hit;
            if (bit_valid) begin
                if (!bit_value) begin
                    ones_run <= '0;
                end else if (ones_run != FLAG_RUN) begin
                    ones_run <= ones_run + 1'b1;    // saturate at six
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_valid) begin
            data_bit <= bit_value;
        end
    end

    a_flag_or_data: assert property (
        @(posedge clk) disable iff (reset)
        !(flag && data_valid)
    );

endmodule

`default_nettype wire

//--- hw/byte_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdlc_rx_config.svh"

module byte_assembler (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   data_valid,
    input  wire                   data_bit,
    input  wire                   flag,
    output sdlc_rx_pkg::rx_byte_t rx_byte,
    output logic                  rx_byte_valid
);
    import sdlc_rx_pkg::*;

    localparam int CNT_W = $clog2(`SDLC_BYTE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SDLC_BYTE_W - 1);

    rx_byte_t         shift_reg;
    logic [CNT_W-1:0] bit_cnt;

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (data_valid && !flag) begin
            shift_reg <= {data_bit, shift_reg[`SDLC_BYTE_W-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt       <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            if (flag) begin
                bit_cnt <= '0;              // resync, drop partial byte
            end else if (data_valid) begin
                if (bit_cnt == LAST_BIT) begin
                    bit_cnt       <= '0;
                    rx_byte_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // shift register is complete in the strobe cycle
    assign rx_byte = shift_reg;

endmodule

`default_nettype wire

//--- hw/sdlc_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdlc_rx_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   rx_clk,
    input  wire                   rx_data,
    output sdlc_rx_pkg::rx_byte_t rx_byte,
    output logic                  rx_byte_valid,
    output logic                  rx_flag
);
    import sdlc_rx_pkg::*;

    logic   bit_strobe;
    phase_t phase;
    logic   bit_valid;
    logic   bit_value;
    logic   data_valid;
    logic   data_bit;

    clock_recovery u_clock_recovery (
        .clk        (clk),
        .reset      (reset),
        .rx_clk     (rx_clk),
        .bit_strobe (bit_strobe),
        .phase      (phase)
    );

    bit_slicer u_bit_slicer (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .bit_strobe (bit_strobe),
        .phase      (phase),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value)
    );

    hdlc_deframer u_hdlc_deframer (
        .clk        (clk),
        .reset      (reset),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .data_valid (data_valid),
        .data_bit   (data_bit),
        .flag       (rx_flag)       // also resyncs the byte counter
    );

    byte_assembler u_byte_assembler (
        .clk           (clk),
        .reset         (reset),
        .data_valid    (data_valid),
        .data_bit      (data_bit),
        .flag          (rx_flag),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid)
    );

endmodule

`default_nettype wire

//--- dv/sdlc_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdlc_rx_config.svh"

module sdlc_rx_checker (
    input wire                        clk,
    input wire                        reset,
    input wire sdlc_rx_pkg::rx_byte_t rx_byte,
    input wire                        rx_byte_valid,
    input wire                        rx_flag
);
    import sdlc_rx_pkg::*;

    localparam int ARM_FLAGS  = 3;                       // receiver trusted from here on
    localparam int DRAIN_CLKS = 64 * `SDLC_BIT_CLKS;

    rx_byte_t expected_q[$];
    int       errors        = 0;
    int       bytes_checked = 0;
    int       flags_seen    = 0;
    int       flags_sent    = 0;

    task automatic push_expected(input rx_byte_t b);
        expected_q.push_back(b);
    endtask

    task automatic note_flag_sent();
        flags_sent++;
    endtask

    task automatic compare_byte();
        rx_byte_t exp_byte;
        if (expected_q.size() == 0) begin
            errors++;
            $display("received byte 0x%02h when no byte was expected", rx_byte);
        end else begin
            exp_byte = expected_q.pop_front();
            bytes_checked++;
            if (rx_byte !== exp_byte) begin
                errors++;
                $display("[ERROR] rx_byte: expected 0x%02h, got 0x%02h", exp_byte, rx_byte);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (rx_byte_valid && (flags_seen >= ARM_FLAGS)) begin
                compare_byte();
            end
            if (rx_flag) begin
                flags_seen++;
            end
        end
    end

    // bytes or flags still owed by the receiver
    function automatic bit work_pending();
        return (expected_q.size() != 0) || (flags_seen < flags_sent);
    endfunction

    // read state away from the sampling edge
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (work_pending() && (cycles < DRAIN_CLKS)) begin
            @(negedge clk);
            cycles++;
        end
        if (work_pending()) begin
            errors++;
            $display("receiver timed out: %0d bytes were missing, %0d of %0d flags seen",
                     expected_q.size(), flags_seen, flags_sent);
        end
    endtask

    task automatic check_totals();
        if (flags_seen != flags_sent) begin
            errors++;
            $display("[ERROR] rx_flag count: expected 0x%0h, got 0x%0h", flags_sent, flags_seen);
        end
    endtask

endmodule

`default_nettype wire

//--- dv/sdlc_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdlc_rx_config.svh"

module sdlc_rx_tb;
    import sdlc_rx_pkg::*;

    localparam int MAX_ROWS   = 16;
    localparam int LEAD_BITS  = 16;     // line held at 0 while the PLL locks
    localparam int OPEN_FLAGS = 4;
    localparam int DATA_DELAY = 2;      // clk from rx_clk rise to data change
    localparam int IDLE_BITS  = 8;

    logic     clk;
    logic     reset;
    logic     rx_clk;
    logic     rx_data;
    rx_byte_t rx_byte;
    logic     rx_byte_valid;
    logic     rx_flag;

    int          row_len   [MAX_ROWS];
    bit          row_rand  [MAX_ROWS];
    logic [63:0] row_bytes [MAX_ROWS];  // first byte in the top bits
    int          n_rows;
    int          stuff_ones;
    logic [31:0] rng_state;

    sdlc_rx_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .rx_clk        (rx_clk),
        .rx_data       (rx_data),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_flag       (rx_flag)
    );

    sdlc_rx_checker chk_i (
        .clk           (clk),
        .reset         (reset),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_flag       (rx_flag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input int len, input bit rnd, input logic [63:0] bytes);
        row_len[n_rows]   = len;
        row_rand[n_rows]  = rnd;
        row_bytes[n_rows] = bytes;
        n_rows++;
    endtask

    // one bit period, rx_clk rises where the bit begins
    task automatic send_bit(input logic b);
        int c;
        for (c = 0; c < `SDLC_BIT_CLKS; c++) begin
            @(posedge clk);
            #1;
            if (c == 0) begin
                rx_clk = 1'b1;
            end
            if (c == `SDLC_BIT_CLKS / 2) begin
                rx_clk = 1'b0;
            end
            if (c == DATA_DELAY) begin
                rx_data = b;
            end
        end
    endtask

    task automatic send_flag();
        logic [7:0] pattern;
        int         i;
        pattern = 8'h7E;
        chk_i.note_flag_sent();
        for (i = 0; i < 8; i++) begin
            send_bit(pattern[i]);           // never stuffed
        end
        stuff_ones = 0;
    endtask

    task automatic send_byte(input rx_byte_t b);
        int i;
        chk_i.push_expected(b);
        for (i = 0; i < `SDLC_BYTE_W; i++) begin
            send_bit(b[i]);                 // lsb first
            stuff_ones = b[i] ? stuff_ones + 1 : 0;
            if (stuff_ones == `SDLC_STUFF_ONES) begin
                send_bit(1'b0);
                stuff_ones = 0;
            end
        end
    endtask

    task automatic send_row(input int r);
        rx_byte_t b;
        int       i;
        for (i = 0; i < row_len[r]; i++) begin
            if (row_rand[r]) begin
                rng_state = xorshift32(rng_state);
                b = rng_state[7:0];
            end else begin
                b = row_bytes[r][63 - 8*i -: 8];
            end
            send_byte(b);
        end
        send_flag();                        // closes this frame, opens the next
    endtask

    initial begin
        int i;
        rx_clk     = 1'b0;
        rx_data    = 1'b0;
        reset      = 1'b1;
        n_rows     = 0;
        stuff_ones = 0;
        rng_state  = 32'd37568;
        add_row(3, 1'b0, 64'h12_34_55_00_00_00_00_00);
        add_row(4, 1'b0, 64'hFF_3E_7C_F8_00_00_00_00);  // all need stuffing
        add_row(3, 1'b0, 64'h11_7E_22_00_00_00_00_00);  // flag pattern as data
        add_row(0, 1'b0, 64'h0);                        // flags back to back
        add_row(0, 1'b0, 64'h0);
        add_row(0, 1'b0, 64'h0);
        add_row(8, 1'b1, 64'h0);
        add_row(8, 1'b0, 64'hFF_FF_00_AA_81_7E_3F_FC);
        add_row(1, 1'b0, 64'hA5_00_00_00_00_00_00_00);
        add_row(2, 1'b0, 64'h5A_1F_00_00_00_00_00_00);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (i = 0; i < LEAD_BITS; i++) begin
            send_bit(1'b0);
        end
        for (i = 0; i < OPEN_FLAGS; i++) begin
            send_flag();
        end
        for (i = 0; i < n_rows; i++) begin
            send_row(i);
        end
        for (i = 0; i < IDLE_BITS; i++) begin
            send_bit(1'b1);                 // mark idle, ones get dropped
        end
        chk_i.wait_drained();
        repeat (IDLE_BITS * `SDLC_BIT_CLKS) @(posedge clk);  // catch stray strobes
        chk_i.check_totals();
        $display("errors: %0d, bytes checked: %0d, flags seen: %0d",
                 chk_i.errors, chk_i.bytes_checked, chk_i.flags_seen);
        if (chk_i.errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/sdlc_rx_pkg.sv
hw/clock_recovery.sv
hw/bit_slicer.sv
hw/hdlc_deframer.sv
hw/byte_assembler.sv
hw/sdlc_rx_top.sv
dv/sdlc_rx_checker.sv
dv/sdlc_rx_tb.sv
